//--- verilog/cmd_engine_settings.svh
/* widths and depths of the command engine
   include wherever one of these macros is needed */

`ifndef CMD_ENGINE_SETTINGS_SVH
`define CMD_ENGINE_SETTINGS_SVH

// data path
`define CE_WORD_W     32    // command / result word, AXI data bus
`define CE_VAL_W      16    // register value and immediate

// register bank
`define CE_NUM_REGS   8

// queues, power of two only
`define CE_CMD_DEPTH  8     // command FIFO
`define CE_RES_DEPTH  8     // result FIFO

// host bus
`define CE_ADDR_W     4     // AXI byte address

`endif

//--- verilog/cmd_engine_pkg.sv
/* command and result types of the engine
   word layouts live in cmd_decode and result_stage */

`include "cmd_engine_settings.svh"

package cmd_engine_pkg;

   // ##################################################
   // plain widths
   // ##################################################
   typedef logic [`CE_WORD_W-1:0]              word_t;     // one host word
   typedef logic [`CE_VAL_W-1:0]               value_t;    // register contents
   typedef logic [$clog2(`CE_NUM_REGS)-1:0]    reg_idx_t;  // bank index
   typedef logic [3:0]                         opcode_t;

   // supported opcodes, everything else is illegal
   localparam opcode_t OP_LOAD = 4'd1;
   localparam opcode_t OP_ADD  = 4'd2;
   localparam opcode_t OP_SUB  = 4'd3;
   localparam opcode_t OP_XOR  = 4'd4;
   localparam opcode_t OP_READ = 4'd5;

   // ##################################################
   // stage payloads
   // ##################################################
   typedef struct packed {
      opcode_t  op;
      reg_idx_t dst;    // written back, except READ
      reg_idx_t src;    // first operand
      value_t   imm;    // second operand
   } cmd_t;

   typedef struct packed {
      opcode_t  op;     // echoed from the command
      reg_idx_t dst;
      value_t   value;  // computed value
   } res_t;

endpackage

//--- verilog/axil_pkg.sv
/* AXI4-Lite channel bundles and the host register map
   request travels host to engine, response the other way */

`include "cmd_engine_settings.svh"

package axil_pkg;

   typedef logic [`CE_ADDR_W-1:0]   addr_t;     // byte address
   typedef logic [`CE_WORD_W-1:0]   data_t;
   typedef logic [`CE_WORD_W/8-1:0] strb_t;
   typedef logic [1:0]              resp_t;

   localparam resp_t RESP_OKAY   = 2'b00;
   localparam resp_t RESP_SLVERR = 2'b10;

   // register map
   localparam addr_t REG_CMD    = 4'h0;    // write pushes a command
   localparam addr_t REG_RESULT = 4'h4;    // read pops a result
   localparam addr_t REG_STATUS = 4'h8;    // counts and sticky error

   typedef struct packed {
      addr_t awaddr;
      logic  awvalid;
      data_t wdata;
      strb_t wstrb;     // full words only, not looked at
      logic  wvalid;
      logic  bready;
      addr_t araddr;
      logic  arvalid;
      logic  rready;
   } axil_req_t;

   typedef struct packed {
      logic  awready;
      logic  wready;
      resp_t bresp;
      logic  bvalid;
      logic  arready;
      data_t rdata;
      resp_t rresp;
      logic  rvalid;
   } axil_rsp_t;

endpackage

//--- verilog/fifo_sync.sv
/* single clock FIFO with a registered read port
   pop while not empty, the word shows on dout one cycle later
   count and the flags follow the pointers with no extra delay */

`timescale 1ns/1ps

module fifo_sync #(
   parameter int DW    = 32,            // word width
   parameter int DEPTH = 8,             // entries, power of two
   localparam int AW   = $clog2(DEPTH)  // array address width
)(
   input  logic          clk,
   input  logic          nreset,
   input  logic          clear,         // synchronous flush
   input  logic          push,
   input  logic [DW-1:0] din,
   output logic          full,
   output logic          almost_full,   // one slot left
   input  logic          pop,
   output logic [DW-1:0] dout,          // valid the cycle after pop
   output logic          empty,
   output logic [AW:0]   count          // entries held, 0 to DEPTH
);

   // ##################################################
   // pointers and flags
   // ##################################################
   logic [AW:0]   wr_ptr;               // msb is the wrap bit
   logic [AW:0]   rd_ptr;
   logic [DW-1:0] mem [DEPTH];          // storage array
   logic          ptr_match;
   logic          do_push;
   logic          do_pop;

   assign ptr_match   = (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
   assign full        = ptr_match && (wr_ptr[AW] != rd_ptr[AW]);  // writer lapped reader
   assign empty       = ptr_match && (wr_ptr[AW] == rd_ptr[AW]);
   assign almost_full = (count == (AW+1)'(DEPTH-1));
   assign do_push     = push && !full;  // never overwrite
   assign do_pop      = pop && !empty;

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else if (clear)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;    // both or neither
         endcase
      end
   end

   // ##################################################
   // array and read register
   // ##################################################
   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr[AW-1:0]] <= din;
      if (do_pop)
         dout <= mem[rd_ptr[AW-1:0]];  // holds until the next pop
   end

   // writer and reader both watch the flags
   a_no_push_full: assert property (@(posedge clk) disable iff (!nreset) !(push && full));
   a_no_pop_empty: assert property (@(posedge clk) disable iff (!nreset) !(pop && empty));

endmodule

//--- verilog/cmd_decode.sv
/* first pipeline stage, pops command words and unpacks them
   illegal opcodes are dropped here with a one-cycle pulse */

`timescale 1ns/1ps

module cmd_decode (
   input  logic                  clk,
   input  logic                  nreset,
   input  cmd_engine_pkg::word_t fifo_dout,
   input  logic                  fifo_empty,
   output logic                  fifo_pop,
   output logic                  dec_valid,
   output cmd_engine_pkg::cmd_t  dec,
   input  logic                  dec_ready,
   output logic                  illegal     // one cycle per dropped word
);

   logic                      pend;          // fifo_dout holds an unused word
   logic                      slot_free;
   logic                      legal;
   logic                      take;          // word leaves fifo_dout
   cmd_engine_pkg::opcode_t   word_op;

   assign word_op   = fifo_dout[31:28];
   assign legal     = word_op inside {cmd_engine_pkg::OP_LOAD, cmd_engine_pkg::OP_ADD,
                                      cmd_engine_pkg::OP_SUB, cmd_engine_pkg::OP_XOR,
                                      cmd_engine_pkg::OP_READ};
   assign slot_free = !dec_valid || dec_ready;   // empty or draining now
   assign take      = pend && (slot_free || !legal);  // bad words never wait
   assign illegal   = pend && !legal;
   // fetch the next word once the current one moves on
   assign fifo_pop  = !fifo_empty && (!pend || take);

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         pend      <= 1'b0;
         dec_valid <= 1'b0;
      end
      else
      begin
         if (fifo_pop)
            pend <= 1'b1;                     // read data lands next cycle
         else if (take)
            pend <= 1'b0;
         if (take && legal)
            dec_valid <= 1'b1;
         else if (dec_ready)
            dec_valid <= 1'b0;
      end
   end

   // unpack the command word
   always_ff @(posedge clk)
   begin
      if (take && legal)
      begin
         dec.op  <= word_op;
         dec.dst <= fifo_dout[26:24];
         dec.src <= fifo_dout[22:20];
         dec.imm <= fifo_dout[15:0];
      end
   end

   // execute may stall, the offer stays put meanwhile
   a_dec_hold: assert property (@(posedge clk) disable iff (!nreset)
      dec_valid && !dec_ready |=> dec_valid && $stable(dec));

endmodule

//--- verilog/cmd_execute.sv
/* second pipeline stage, owns the register bank
   one command per cycle, the bank is written on acceptance so
   the next command already sees the new value */

`timescale 1ns/1ps

`include "cmd_engine_settings.svh"

module cmd_execute (
   input  logic                 clk,
   input  logic                 nreset,
   input  logic                 dec_valid,
   input  cmd_engine_pkg::cmd_t dec,
   output logic                 dec_ready,
   output logic                 exe_valid,
   output cmd_engine_pkg::res_t res,
   input  logic                 exe_ready
);

   cmd_engine_pkg::value_t bank [`CE_NUM_REGS];   // architectural registers
   cmd_engine_pkg::value_t src_val;
   cmd_engine_pkg::value_t new_val;
   logic                   accept;

   assign dec_ready = !exe_valid || exe_ready;    // output slot frees up
   assign accept    = dec_valid && dec_ready;
   assign src_val   = bank[dec.src];

   // ##################################################
   // arithmetic, wraps at 16 bits
   // ##################################################
   always_comb
   begin
      case (dec.op)
         cmd_engine_pkg::OP_LOAD: new_val = dec.imm;
         cmd_engine_pkg::OP_ADD:  new_val = src_val + dec.imm;
         cmd_engine_pkg::OP_SUB:  new_val = src_val - dec.imm;
         cmd_engine_pkg::OP_XOR:  new_val = src_val ^ dec.imm;
         cmd_engine_pkg::OP_READ: new_val = src_val;  // no write back
         default:                 new_val = '0;       // filtered by decode
      endcase
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         exe_valid <= 1'b0;
         for (int i = 0; i < `CE_NUM_REGS; i++)
            bank[i] <= '0;
      end
      else
      begin
         if (accept)
            exe_valid <= 1'b1;
         else if (exe_ready)
            exe_valid <= 1'b0;
         if (accept && dec.op != cmd_engine_pkg::OP_READ)
            bank[dec.dst] <= new_val;
      end
   end

   // result payload for the last stage
   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         res.op    <= dec.op;
         res.dst   <= dec.dst;
         res.value <= new_val;
      end
   end

endmodule

//--- verilog/result_stage.sv
/* last pipeline stage, formats one result word per command
   and pushes it into the result FIFO once there is room */

`timescale 1ns/1ps

module result_stage (
   input  logic                  clk,
   input  logic                  nreset,
   input  logic                  exe_valid,
   input  cmd_engine_pkg::res_t  res,
   output logic                  exe_ready,
   input  logic                  fifo_full,
   output logic                  fifo_push,
   output cmd_engine_pkg::word_t fifo_din
);

   logic hold_valid;                               // fifo_din is a live word

   assign fifo_push = hold_valid && !fifo_full;
   assign exe_ready = !hold_valid || fifo_push;    // stall only on a full queue

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         hold_valid <= 1'b0;
      else if (exe_valid && exe_ready)
         hold_valid <= 1'b1;
      else if (fifo_push)
         hold_valid <= 1'b0;
   end

   // op 31:28, dst 26:24, value 15:0, rest zero
   always_ff @(posedge clk)
   begin
      if (exe_valid && exe_ready)
         fifo_din <= {res.op, 1'b0, res.dst, 8'h00, res.value};
   end

endmodule

//--- verilog/axil_regs.sv
/* AXI4-Lite slave for the host side, one write and one read at a time
   CMD pushes the command FIFO, RESULT pops the result FIFO,
   STATUS reports both counts and the sticky illegal bit */

`timescale 1ns/1ps

`include "cmd_engine_settings.svh"

module axil_regs (
   input  logic                             clk,
   input  logic                             nreset,
   input  axil_pkg::axil_req_t              req,
   output axil_pkg::axil_rsp_t              rsp,
   output logic                             cmd_push,
   output cmd_engine_pkg::word_t            cmd_data,
   input  logic                             cmd_full,
   input  logic [$clog2(`CE_CMD_DEPTH):0]   cmd_count,
   output logic                             res_pop,
   input  cmd_engine_pkg::word_t            res_dout,
   input  logic                             res_empty,
   input  logic [$clog2(`CE_RES_DEPTH):0]   res_count,
   input  logic                             illegal      // pulse from decode
);

   typedef enum logic {W_IDLE, W_RESP} w_state_t;
   typedef enum logic [1:0] {R_IDLE, R_WAIT, R_RESP} r_state_t;

   w_state_t              w_state;
   r_state_t              r_state;
   logic                  wr_go;          // AW and W taken together
   logic                  rd_go;
   logic                  status_wr;
   logic                  illegal_q;      // sticky
   logic                  popped_q;       // read found a result
   axil_pkg::addr_t       rd_addr_q;
   axil_pkg::resp_t       bresp_q;
   axil_pkg::resp_t       rresp_q;
   cmd_engine_pkg::word_t rdata_q;
   cmd_engine_pkg::word_t status_word;

   // ##################################################
   // write channel
   // ##################################################
   assign wr_go     = (w_state == W_IDLE) && req.awvalid && req.wvalid;
   assign cmd_push  = wr_go && (req.awaddr == axil_pkg::REG_CMD) && !cmd_full;
   assign cmd_data  = req.wdata;
   assign status_wr = wr_go && (req.awaddr == axil_pkg::REG_STATUS);

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         w_state <= W_IDLE;
      else
         case (w_state)
            W_IDLE:  if (wr_go) w_state <= W_RESP;
            W_RESP:  if (req.bready) w_state <= W_IDLE;
            default: w_state <= W_IDLE;
         endcase
   end

   // full queue or unknown offset gets SLVERR
   always_ff @(posedge clk)
   begin
      if (wr_go)
         bresp_q <= (cmd_push || status_wr) ? axil_pkg::RESP_OKAY : axil_pkg::RESP_SLVERR;
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         illegal_q <= 1'b0;
      else if (illegal)
         illegal_q <= 1'b1;          // a new error beats the clear
      else if (status_wr)
         illegal_q <= 1'b0;
   end

   // ##################################################
   // read channel
   // ##################################################
   assign rd_go   = (r_state == R_IDLE) && req.arvalid;
   assign res_pop = rd_go && (req.araddr == axil_pkg::REG_RESULT) && !res_empty;

   always_comb
   begin
      status_word      = '0;
      status_word[3:0] = cmd_count;
      status_word[7:4] = res_count;
      status_word[8]   = illegal_q;
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         r_state <= R_IDLE;
      else
         case (r_state)
            R_IDLE:  if (rd_go) r_state <= R_WAIT;
            R_WAIT:  r_state <= R_RESP;          // FIFO dout settles here
            R_RESP:  if (req.rready) r_state <= R_IDLE;
            default: r_state <= R_IDLE;
         endcase
   end

   always_ff @(posedge clk)
   begin
      if (rd_go)
      begin
         rd_addr_q <= req.araddr;
         popped_q  <= res_pop;
      end
      if (r_state == R_WAIT)
      begin
         if (rd_addr_q == axil_pkg::REG_RESULT && popped_q)
         begin
            rdata_q <= res_dout;
            rresp_q <= axil_pkg::RESP_OKAY;
         end
         else if (rd_addr_q == axil_pkg::REG_STATUS)
         begin
            rdata_q <= status_word;
            rresp_q <= axil_pkg::RESP_OKAY;
         end
         else
         begin
            rdata_q <= '0;                  // empty queue or bad offset
            rresp_q <= axil_pkg::RESP_SLVERR;
         end
      end
   end

   always_comb
   begin
      rsp.awready = wr_go;
      rsp.wready  = wr_go;
      rsp.bresp   = bresp_q;
      rsp.bvalid  = (w_state == W_RESP);
      rsp.arready = rd_go;
      rsp.rdata   = rdata_q;
      rsp.rresp   = rresp_q;
      rsp.rvalid  = (r_state == R_RESP);
   end

   // responses stay up and unchanged until the host takes them
   a_b_hold: assert property (@(posedge clk) disable iff (!nreset)
      rsp.bvalid && !req.bready |=> rsp.bvalid && $stable(rsp.bresp));
   a_r_hold: assert property (@(posedge clk) disable iff (!nreset)
      rsp.rvalid && !req.rready |=> rsp.rvalid && $stable(rsp.rdata));

endmodule

//--- verilog/cmd_engine_top.sv
/* command engine top, AXI4-Lite front end feeding a command FIFO,
   decode, execute and result stages, and a result FIFO read back
   by the host */

`timescale 1ns/1ps

`include "cmd_engine_settings.svh"

module cmd_engine_top (
   input  logic                clk,
   input  logic                nreset,
   input  axil_pkg::axil_req_t axil_req,
   output axil_pkg::axil_rsp_t axil_rsp
);

   // ##################################################
   // wires
   // ##################################################
   logic                           cmd_push, cmd_full, cmd_pop, cmd_empty;
   logic                           res_push, res_full, res_pop, res_empty;
   logic [$clog2(`CE_CMD_DEPTH):0] cmd_count;
   logic [$clog2(`CE_RES_DEPTH):0] res_count;
   cmd_engine_pkg::word_t          cmd_data, cmd_dout;   // host side, decode side
   cmd_engine_pkg::word_t          res_din, res_dout;
   logic                           dec_valid, dec_ready, illegal;
   logic                           exe_valid, exe_ready;
   cmd_engine_pkg::cmd_t           dec;
   cmd_engine_pkg::res_t           res;

   axil_regs axil_regs_inst (
      .clk       (clk),
      .nreset    (nreset),
      .req       (axil_req),
      .rsp       (axil_rsp),
      .cmd_push  (cmd_push),
      .cmd_data  (cmd_data),
      .cmd_full  (cmd_full),
      .cmd_count (cmd_count),
      .res_pop   (res_pop),
      .res_dout  (res_dout),
      .res_empty (res_empty),
      .res_count (res_count),
      .illegal   (illegal)
   );

   // host to pipeline
   fifo_sync #(.DW(`CE_WORD_W), .DEPTH(`CE_CMD_DEPTH)) cmd_fifo (
      .clk         (clk),
      .nreset      (nreset),
      .clear       (1'b0),
      .push        (cmd_push),
      .din         (cmd_data),
      .full        (cmd_full),
      .almost_full (),
      .pop         (cmd_pop),
      .dout        (cmd_dout),
      .empty       (cmd_empty),
      .count       (cmd_count)
   );

   cmd_decode cmd_decode_inst (
      .clk        (clk),
      .nreset     (nreset),
      .fifo_dout  (cmd_dout),
      .fifo_empty (cmd_empty),
      .fifo_pop   (cmd_pop),
      .dec_valid  (dec_valid),
      .dec        (dec),
      .dec_ready  (dec_ready),
      .illegal    (illegal)
   );

   cmd_execute cmd_execute_inst (
      .clk       (clk),
      .nreset    (nreset),
      .dec_valid (dec_valid),
      .dec       (dec),
      .dec_ready (dec_ready),
      .exe_valid (exe_valid),
      .res       (res),
      .exe_ready (exe_ready)
   );

   result_stage result_stage_inst (
      .clk       (clk),
      .nreset    (nreset),
      .exe_valid (exe_valid),
      .res       (res),
      .exe_ready (exe_ready),
      .fifo_full (res_full),
      .fifo_push (res_push),
      .fifo_din  (res_din)
   );

   // pipeline to host, full here backs up every stage
   fifo_sync #(.DW(`CE_WORD_W), .DEPTH(`CE_RES_DEPTH)) res_fifo (
      .clk         (clk),
      .nreset      (nreset),
      .clear       (1'b0),
      .push        (res_push),
      .din         (res_din),
      .full        (res_full),
      .almost_full (),
      .pop         (res_pop),
      .dout        (res_dout),
      .empty       (res_empty),
      .count       (res_count)
   );

endmodule

//--- sim/tb_cmd_engine.sv
/* testbench for the command engine, drives host traffic over AXI4-Lite
   and checks every result word against a reference model of the bank */

`timescale 1ns/1ps

`include "cmd_engine_settings.svh"

module tb_cmd_engine;

   localparam int HALF_PERIOD = 50;     // 100 ns clock
   localparam int MAX_WAIT    = 200;    // cycles per handshake
   localparam int MAX_POLLS   = 100;    // RESULT reads per word

   typedef cmd_engine_pkg::value_t bank_t [`CE_NUM_REGS];

   logic                  clk;
   logic                  nreset;
   axil_pkg::axil_req_t   req;
   axil_pkg::axil_rsp_t   rsp;
   bank_t                 model;        // expected register bank
   cmd_engine_pkg::word_t exp_q [$];    // expected results in order
   cmd_engine_pkg::word_t got_q [$];    // read back but not compared yet
   integer                seed;

   cmd_engine_top cmd_engine_top_inst (
      .clk      (clk),
      .nreset   (nreset),
      .axil_req (req),
      .axil_rsp (rsp)
   );

   initial
   begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   // ##################################################
   // reporting
   // ##################################################
   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Result: FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp)
      else stop_run($sformatf("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp));
   endtask

   // ##################################################
   // reference model
   // ##################################################
   function automatic cmd_engine_pkg::word_t ref_result(
      input  cmd_engine_pkg::word_t cmd,
      inout  bank_t                 regs,
      output bit                    bad
   );
      logic [3:0]  op;
      logic [2:0]  dst;
      logic [2:0]  src;
      logic [15:0] imm;
      logic [15:0] val;
      op  = cmd[31:28];
      dst = cmd[26:24];
      src = cmd[22:20];
      imm = cmd[15:0];
      bad = 1'b0;
      val = '0;
      case (op)
         cmd_engine_pkg::OP_LOAD: val = imm;
         cmd_engine_pkg::OP_ADD:  val = regs[src] + imm;   // wraps at 16 bits
         cmd_engine_pkg::OP_SUB:  val = regs[src] - imm;
         cmd_engine_pkg::OP_XOR:  val = regs[src] ^ imm;
         cmd_engine_pkg::OP_READ: val = regs[src];
         default:                 bad = 1'b1;              // dropped without a result
      endcase
      if (!bad && op != cmd_engine_pkg::OP_READ)
         regs[dst] = val;
      return bad ? '0 : {op, 1'b0, dst, 8'h00, val};
   endfunction

   function automatic cmd_engine_pkg::word_t make_cmd(input logic [3:0] op,
      input logic [2:0] dst, input logic [2:0] src, input logic [15:0] imm);
      return {op, 1'b0, dst, 1'b0, src, 4'h0, imm};
   endfunction

   // legal opcode with noise in the ignored bits
   function automatic cmd_engine_pkg::word_t random_cmd();
      logic [31:0] r;
      logic [31:0] s;
      logic [3:0]  op;
      r  = $random(seed);
      s  = $random(seed);
      op = 4'd1 + 4'(r[7:0] % 8'd5);
      return {op, s[27], r[10:8], s[23], r[13:11], s[19:16], s[15:0]};
   endfunction

   // ##################################################
   // AXI4-Lite host tasks
   // ##################################################
   task automatic axil_write(input axil_pkg::addr_t addr, input axil_pkg::data_t data,
                             output axil_pkg::resp_t resp);
      int waited;
      waited = 0;
      @(negedge clk);
      req.awaddr  = addr;
      req.awvalid = 1'b1;
      req.wdata   = data;
      req.wstrb   = '1;
      req.wvalid  = 1'b1;
      req.bready  = 1'b0;               // hold B until we have seen it
      @(posedge clk);                   // handshake happens on this edge
      while (!rsp.awready)
      begin
         waited++;
         if (waited > MAX_WAIT)
            stop_run("write address was never accepted by the host port");
         @(posedge clk);
      end
      check_value("wready", rsp.wready, 1'b1);   // AW and W taken together
      @(negedge clk);
      req.awvalid = 1'b0;
      req.wvalid  = 1'b0;
      waited      = 0;
      while (!rsp.bvalid)
      begin
         waited++;
         if (waited > MAX_WAIT)
            stop_run("write to the host port got no B response in time");
         @(negedge clk);
      end
      resp        = rsp.bresp;
      req.bready  = 1'b1;
      @(negedge clk);
      req.bready  = 1'b0;
   endtask

   task automatic axil_read(input axil_pkg::addr_t addr, output axil_pkg::data_t data,
                            output axil_pkg::resp_t resp);
      int waited;
      waited = 0;
      @(negedge clk);
      req.araddr  = addr;
      req.arvalid = 1'b1;
      req.rready  = 1'b0;
      @(posedge clk);                   // handshake happens on this edge
      while (!rsp.arready)
      begin
         waited++;
         if (waited > MAX_WAIT)
            stop_run("read address was never accepted by the host port");
         @(posedge clk);
      end
      @(negedge clk);
      req.arvalid = 1'b0;
      waited      = 0;
      while (!rsp.rvalid)
      begin
         waited++;
         if (waited > MAX_WAIT)
            stop_run("read from the host port got no R response in time");
         @(negedge clk);
      end
      data        = rsp.rdata;
      resp        = rsp.rresp;
      req.rready  = 1'b1;
      @(negedge clk);
      req.rready  = 1'b0;
   endtask

   // ##################################################
   // command and result helpers
   // ##################################################
   task automatic send_cmd(input cmd_engine_pkg::word_t cmd, output axil_pkg::resp_t resp);
      bit                    bad;
      cmd_engine_pkg::word_t exp;
      axil_write(axil_pkg::REG_CMD, cmd, resp);
      if (resp == axil_pkg::RESP_OKAY)  // only accepted words reach the model
      begin
         exp = ref_result(cmd, model, bad);
         if (!bad)
            exp_q.push_back(exp);
      end
   endtask

   task automatic send_ok(input cmd_engine_pkg::word_t cmd);
      axil_pkg::resp_t resp;
      send_cmd(cmd, resp);
      check_value("bresp", resp, axil_pkg::RESP_OKAY);
   endtask

   task automatic fetch_result();
      axil_pkg::data_t data;
      axil_pkg::resp_t resp;
      int              polls;
      polls = 0;
      axil_read(axil_pkg::REG_RESULT, data, resp);
      while (resp != axil_pkg::RESP_OKAY)
      begin
         check_value("rdata", data, 32'h0);   // empty queue reads zero
         polls++;
         if (polls > MAX_POLLS)
            stop_run("no result word showed up while polling RESULT");
         axil_read(axil_pkg::REG_RESULT, data, resp);
      end
      got_q.push_back(data);
   endtask

   task automatic try_result();
      axil_pkg::data_t data;
      axil_pkg::resp_t resp;
      axil_read(axil_pkg::REG_RESULT, data, resp);
      if (resp == axil_pkg::RESP_OKAY)
         got_q.push_back(data);
      else
         check_value("rdata", data, 32'h0);
   endtask

   task automatic drain_results();
      while (exp_q.size() > got_q.size())   // compare pops both queues together
         fetch_result();
   endtask

   task automatic wait_compared();
      int waited;
      waited = 0;
      while (got_q.size() > 0)
      begin
         waited++;
         if (waited > MAX_WAIT)
            stop_run("compare process fell behind the read-back words");
         @(negedge clk);
      end
   endtask

   task automatic check_status(input logic [31:0] exp);
      axil_pkg::data_t data;
      axil_pkg::resp_t resp;
      axil_read(axil_pkg::REG_STATUS, data, resp);
      check_value("rresp", resp, axil_pkg::RESP_OKAY);
      check_value("status", data, exp);
   endtask

   // head of the expected queue against each word read back
   initial
   begin
      forever
      begin
         @(posedge clk);
         while (got_q.size() > 0)
         begin
            if (exp_q.size() == 0)
               stop_run("RESULT returned a word that no command asked for");
            check_value("rdata", got_q.pop_front(), exp_q.pop_front());
         end
      end
   end

   // ##################################################
   // main sequence
   // ##################################################
   initial
   begin
      axil_pkg::data_t       data;
      axil_pkg::resp_t       resp;
      cmd_engine_pkg::word_t cmd;
      int                    tries;
      req    = '0;
      nreset = 1'b0;
      seed   = 32'hc9c6_a482;
      for (int i = 0; i < `CE_NUM_REGS; i++)
         model[i] = '0;
      repeat (4) @(negedge clk);
      nreset = 1'b1;

      // idle engine
      check_status(32'h0);
      axil_read(axil_pkg::REG_RESULT, data, resp);
      check_value("rresp", resp, axil_pkg::RESP_SLVERR);
      check_value("rdata", data, 32'h0);

      // directed dependent chain and wraps
      send_ok(make_cmd(cmd_engine_pkg::OP_LOAD, 3'd1, 3'd0, 16'h1234));
      send_ok(make_cmd(cmd_engine_pkg::OP_ADD,  3'd2, 3'd1, 16'h0001));
      send_ok(make_cmd(cmd_engine_pkg::OP_SUB,  3'd3, 3'd2, 16'h2000));   // below zero
      send_ok(make_cmd(cmd_engine_pkg::OP_XOR,  3'd4, 3'd3, 16'h0ff0));
      send_ok(make_cmd(cmd_engine_pkg::OP_LOAD, 3'd5, 3'd0, 16'hfff0));
      send_ok(make_cmd(cmd_engine_pkg::OP_ADD,  3'd5, 3'd5, 16'h0020));   // past 0xffff
      send_ok(make_cmd(cmd_engine_pkg::OP_SUB,  3'd6, 3'd0, 16'h0001));
      send_ok(make_cmd(cmd_engine_pkg::OP_READ, 3'd7, 3'd4, 16'h0000));
      send_ok(make_cmd(cmd_engine_pkg::OP_READ, 3'd0, 3'd7, 16'h0000));   // r7 untouched
      drain_results();
      wait_compared();

      // unknown opcode sets the sticky bit, then a STATUS write clears it
      send_ok(32'hf5a5_5a5a);
      tries = 0;
      axil_read(axil_pkg::REG_STATUS, data, resp);
      while (!data[8])
      begin
         tries++;
         if (tries > MAX_POLLS)
            stop_run("illegal bit never showed up in STATUS");
         axil_read(axil_pkg::REG_STATUS, data, resp);
      end
      check_status(32'h100);
      axil_read(axil_pkg::REG_RESULT, data, resp);
      check_value("rresp", resp, axil_pkg::RESP_SLVERR);
      axil_write(axil_pkg::REG_STATUS, 32'h0, resp);
      check_value("bresp", resp, axil_pkg::RESP_OKAY);
      check_status(32'h0);

      // back-pressure fills every stage until CMD refuses
      resp  = axil_pkg::RESP_OKAY;
      tries = 0;
      while (resp == axil_pkg::RESP_OKAY)
      begin
         tries++;
         if (tries > 64)
            stop_run("command queue never filled up under back-pressure");
         send_cmd(random_cmd(), resp);
      end
      assert (exp_q.size() >= `CE_CMD_DEPTH + `CE_RES_DEPTH)
      else stop_run("fewer commands accepted than both queues can hold");
      drain_results();
      wait_compared();
      check_status(32'h0);

      // random stream with interleaved reads
      for (int i = 0; i < 200; i++)
      begin
         cmd   = random_cmd();
         tries = 0;
         send_cmd(cmd, resp);
         while (resp != axil_pkg::RESP_OKAY)   // queue full so read one and retry
         begin
            tries++;
            if (tries > 8)
               stop_run("command kept being refused after results were read");
            fetch_result();
            send_cmd(cmd, resp);
         end
         if ($random(seed) & 1)
            try_result();
      end
      drain_results();
      wait_compared();
      axil_read(axil_pkg::REG_RESULT, data, resp);
      check_value("rresp", resp, axil_pkg::RESP_SLVERR);   // no word left behind
      check_value("rdata", data, 32'h0);
      check_status(32'h0);

      $display("Result: PASSED");
      $finish;
   end

endmodule

//--- cmd_engine_top.f
+incdir+verilog
verilog/cmd_engine_pkg.sv
verilog/axil_pkg.sv
verilog/fifo_sync.sv
verilog/cmd_decode.sv
verilog/cmd_execute.sv
verilog/result_stage.sv
verilog/axil_regs.sv
verilog/cmd_engine_top.sv
sim/tb_cmd_engine.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f cmd_engine_top.f \
   --top-module tb_cmd_engine > sim.log 2>&1 \
   && ./obj_dir/Vtb_cmd_engine >> sim.log 2>&1 \
   || echo "Result: FAILED" >> sim.log
grep -q "Result: FAILED" sim.log && { echo "simulation failed, see sim.log"; exit 1; } \
   || { echo "simulation passed"; exit 0; }
